/* frame_apb_regs.sv */
`timescale 1ns/100ps

module frame_apb_regs #(
    parameter int NUM_LANES = 2
) (
    input  logic                                  ACLK,
    input  logic                                  ARESET,
    input  logic [frame_pkg::ADDR_W-1:0]          paddr,
    input  logic                                  psel,
    input  logic                                  penable,
    input  logic                                  pwrite,
    input  frame_pkg::word_t                      pwdata,
    input  logic [NUM_LANES-1:0]                  lane_ovf,
    input  logic                                  frame_done,
    output frame_pkg::word_t                      prdata,
    output logic                                  pready,
    output logic                                  pslverr,
    output logic [NUM_LANES-1:0]                  lane_en,
    output logic [NUM_LANES*frame_pkg::LEN_W-1:0] lane_len,
    output logic                                  error
);

    logic                  access;
    logic                  wr;
    logic                  mapped;
    logic [NUM_LANES-1:0]  status;
    logic [NUM_LANES-1:0]  clr_mask;
    frame_pkg::word_t      frames;

    // no wait states
    assign pready = 1'b1;
    assign access = psel && penable;
    assign wr     = access && pwrite;

    assign clr_mask = (wr && paddr == frame_pkg::REG_STATUS) ? pwdata[NUM_LANES-1:0] : '0;
    assign error    = |status;
    assign pslverr  = access && !mapped;

    // read mux and address decode
    always_comb begin
        mapped = 1'b1;
        prdata = '0;
        case (paddr)
            frame_pkg::REG_CTRL:   prdata[NUM_LANES-1:0] = lane_en;
            frame_pkg::REG_STATUS: prdata[NUM_LANES-1:0] = status;
            frame_pkg::REG_FRAMES: prdata = frames;
            default:               mapped = 1'b0;
        endcase
        for (int n = 0; n < NUM_LANES; n++) begin
            if (paddr == frame_pkg::REG_LEN_BASE + frame_pkg::ADDR_W'(4 * n)) begin
                mapped                        = 1'b1;
                prdata[frame_pkg::LEN_W-1:0]  = lane_len[n*frame_pkg::LEN_W +: frame_pkg::LEN_W];
            end
        end
    end

    always_ff @(posedge ACLK) begin
        if (ARESET) begin
            lane_en  <= '0;
            lane_len <= '0;
            status   <= '0;
            frames   <= '0;
        end else begin
            if (wr && paddr == frame_pkg::REG_CTRL) begin
                lane_en <= pwdata[NUM_LANES-1:0];
            end
            for (int n = 0; n < NUM_LANES; n++) begin
                if (wr && paddr == frame_pkg::REG_LEN_BASE + frame_pkg::ADDR_W'(4 * n)) begin
                    lane_len[n*frame_pkg::LEN_W +: frame_pkg::LEN_W] <=
                        pwdata[frame_pkg::LEN_W-1:0];
                end
            end
            // a new overflow wins over a clear in the same cycle
            status <= (status & ~clr_mask) | lane_ovf;
            if (frame_done) begin
                frames <= frames + 1'b1;
            end
        end
    end

    a_penable_needs_psel: assert property (@(posedge ACLK) disable iff (ARESET)
        penable |-> psel);

    // setup cycle is always followed by the access cycle
    a_setup_then_access: assert property (@(posedge ACLK) disable iff (ARESET)
        psel && !penable |=> psel && penable);

endmodule

/* frame_lane.sv */
`timescale 1ns/100ps

module frame_lane #(
    parameter int LANE_ID    = 0,
    parameter int FIFO_DEPTH = 16
) (
    input  logic                   ACLK,
    input  logic                   ARESET,
    input  logic                   sample_valid,
    input  frame_pkg::word_t       sample_data,
    input  logic                   enable,
    input  frame_pkg::frame_len_t  frame_len,
    input  logic                   out_ready,
    output logic                   ovf,
    output logic                   out_valid,
    output frame_pkg::word_t       out_data,
    output logic                   out_last
);

    localparam int CNT_W = $clog2(FIFO_DEPTH) + 1;

    frame_pkg::lane_state_t  state;
    frame_pkg::frame_len_t   len_q;
    frame_pkg::frame_len_t   remaining;
    frame_pkg::seq_t         seq;
    frame_pkg::csum_t        csum;
    frame_pkg::word_t        fifo_data;
    logic [CNT_W-1:0]        fifo_count;
    logic                    fifo_pop;
    logic                    start;
    logic                    accept;

    sample_fifo #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) u_fifo (
        .ACLK      (ACLK),
        .ARESET    (ARESET),
        .push      (sample_valid),
        .push_data (sample_data),
        .pop       (fifo_pop),
        .pop_data  (fifo_data),
        .count     (fifo_count),
        .overflow  (ovf)
    );

    // a whole frame must be buffered before the header goes out
    assign start = (state == frame_pkg::IDLE) && enable && (frame_len != '0) &&
                   (frame_pkg::frame_len_t'(fifo_count) >= frame_len);

    assign out_valid = (state != frame_pkg::IDLE);
    assign accept    = out_valid && out_ready;
    assign fifo_pop  = (state == frame_pkg::SAMPLES) && out_ready;
    assign out_last  = (state == frame_pkg::FOOTER);

    always_comb begin
        case (state)
            frame_pkg::HEADER: begin
                out_data = {frame_pkg::HDR_MAGIC, frame_pkg::lane_id_t'(LANE_ID), len_q, seq};
            end
            frame_pkg::FOOTER: begin
                out_data = {frame_pkg::FTR_MAGIC, seq, csum};
            end
            default: begin
                out_data = fifo_data;
            end
        endcase
    end

    always_ff @(posedge ACLK) begin
        if (ARESET) begin
            state <= frame_pkg::IDLE;
            seq   <= '0;
        end else begin
            case (state)
                frame_pkg::IDLE: begin
                    if (start) begin
                        state <= frame_pkg::HEADER;
                    end
                end
                frame_pkg::HEADER: begin
                    if (accept) begin
                        state <= frame_pkg::SAMPLES;
                    end
                end
                frame_pkg::SAMPLES: begin
                    if (accept && remaining == frame_pkg::frame_len_t'(1)) begin
                        state <= frame_pkg::FOOTER;
                    end
                end
                default: begin
                    if (accept) begin
                        state <= frame_pkg::IDLE;
                        seq   <= seq + 1'b1;
                    end
                end
            endcase
        end
    end

    // frame length latched at start and checksum folded per sample
    always_ff @(posedge ACLK) begin
        if (start) begin
            len_q     <= frame_len;
            remaining <= frame_len;
            csum      <= '0;
        end else if (fifo_pop) begin
            remaining <= remaining - 1'b1;
            csum      <= csum ^ fifo_data[31:16] ^ fifo_data[15:0];
        end
    end

    a_hold_until_accepted: assert property (@(posedge ACLK) disable iff (ARESET)
        out_valid && !out_ready |=> out_valid && $stable(out_data) && $stable(out_last));

endmodule

/* frame_merge.sv */
`timescale 1ns/100ps

module frame_merge #(
    parameter int NUM_LANES = 2
) (
    input  logic                                   ACLK,
    input  logic                                   ARESET,
    input  logic [NUM_LANES-1:0]                   lane_valid,
    input  logic [NUM_LANES*frame_pkg::WORD_W-1:0] lane_data,
    input  logic [NUM_LANES-1:0]                   lane_last,
    input  logic                                   m_ready,
    output logic [NUM_LANES-1:0]                   lane_ready,
    output logic                                   m_valid,
    output frame_pkg::word_t                       m_data,
    output logic                                   m_last,
    output logic                                   frame_done
);

    localparam int OWN_W = (NUM_LANES > 1) ? $clog2(NUM_LANES) : 1;

    logic              locked;
    logic [OWN_W-1:0]  owner;
    logic [OWN_W-1:0]  cand;
    logic [OWN_W-1:0]  sel;
    logic              found;

    // next requesting lane searched from the one after the last owner
    always_comb begin
        cand  = owner;
        found = 1'b0;
        for (int i = 1; i <= NUM_LANES; i++) begin
            if (!found && lane_valid[(int'(owner) + i) % NUM_LANES]) begin
                found = 1'b1;
                cand  = OWN_W'((int'(owner) + i) % NUM_LANES);
            end
        end
    end

    assign sel        = locked ? owner : cand;
    assign m_valid    = lane_valid[sel];
    assign m_data     = lane_data[sel*frame_pkg::WORD_W +: frame_pkg::WORD_W];
    assign m_last     = lane_last[sel];
    assign lane_ready = NUM_LANES'(m_ready) << sel;
    assign frame_done = m_valid && m_ready && m_last;

    always_ff @(posedge ACLK) begin
        if (ARESET) begin
            locked <= 1'b0;
            owner  <= OWN_W'(NUM_LANES - 1);
        end else if (m_valid) begin
            // hold the lane from its first word until the last one is taken
            locked <= !frame_done;
            owner  <= sel;
        end
    end

    // a locked lane has no gap before its last word
    a_locked_lane_valid: assert property (@(posedge ACLK) disable iff (ARESET)
        locked |-> lane_valid[owner]);

    a_out_stable: assert property (@(posedge ACLK) disable iff (ARESET)
        m_valid && !m_ready |=> m_valid && $stable(m_data));

endmodule

/* frame_pkg.sv */
package frame_pkg;

    // field widths
    localparam int WORD_W    = 32;
    localparam int LEN_W     = 12;
    localparam int SEQ_W     = 8;
    localparam int LANE_ID_W = 4;
    localparam int CSUM_W    = 16;
    localparam int ADDR_W    = 12;

    typedef logic [WORD_W-1:0]    word_t;
    typedef logic [LEN_W-1:0]     frame_len_t;
    typedef logic [SEQ_W-1:0]     seq_t;
    typedef logic [LANE_ID_W-1:0] lane_id_t;
    typedef logic [CSUM_W-1:0]    csum_t;

    // top byte of header and footer words
    localparam logic [7:0] HDR_MAGIC = 8'hA5;
    localparam logic [7:0] FTR_MAGIC = 8'h5A;

    // register map, length of lane n at REG_LEN_BASE + 4n
    localparam logic [ADDR_W-1:0] REG_CTRL     = 12'h000;
    localparam logic [ADDR_W-1:0] REG_STATUS   = 12'h004;
    localparam logic [ADDR_W-1:0] REG_FRAMES   = 12'h008;
    localparam logic [ADDR_W-1:0] REG_LEN_BASE = 12'h010;

    typedef enum logic [1:0] {
        IDLE,
        HEADER,
        SAMPLES,
        FOOTER
    } lane_state_t;

endpackage

/* frame_top.sv */
`timescale 1ns/100ps

module frame_top #(
    parameter int NUM_LANES  = 2,
    parameter int FIFO_DEPTH = 16
) (
    input  logic                                   ACLK,
    input  logic                                   ARESET,
    input  logic [frame_pkg::ADDR_W-1:0]           paddr,
    input  logic                                   psel,
    input  logic                                   penable,
    input  logic                                   pwrite,
    input  frame_pkg::word_t                       pwdata,
    output frame_pkg::word_t                       prdata,
    output logic                                   pready,
    output logic                                   pslverr,
    input  logic [NUM_LANES-1:0]                   sample_valid,
    input  logic [NUM_LANES*frame_pkg::WORD_W-1:0] sample_data,
    input  logic                                   m_ready,
    output logic                                   m_valid,
    output frame_pkg::word_t                       m_data,
    output logic                                   m_last,
    output logic                                   error
);

    logic [NUM_LANES-1:0]                   lane_en;
    logic [NUM_LANES*frame_pkg::LEN_W-1:0]  lane_len;
    logic [NUM_LANES-1:0]                   lane_ovf;
    logic [NUM_LANES-1:0]                   lane_valid;
    logic [NUM_LANES*frame_pkg::WORD_W-1:0] lane_data;
    logic [NUM_LANES-1:0]                   lane_last;
    logic [NUM_LANES-1:0]                   lane_ready;
    logic                                   frame_done;

    frame_apb_regs #(
        .NUM_LANES (NUM_LANES)
    ) u_regs (
        .ACLK       (ACLK),
        .ARESET     (ARESET),
        .paddr      (paddr),
        .psel       (psel),
        .penable    (penable),
        .pwrite     (pwrite),
        .pwdata     (pwdata),
        .lane_ovf   (lane_ovf),
        .frame_done (frame_done),
        .prdata     (prdata),
        .pready     (pready),
        .pslverr    (pslverr),
        .lane_en    (lane_en),
        .lane_len   (lane_len),
        .error      (error)
    );

    for (genvar g = 0; g < NUM_LANES; g++) begin : g_lane
        frame_lane #(
            .LANE_ID    (g),
            .FIFO_DEPTH (FIFO_DEPTH)
        ) u_lane (
            .ACLK         (ACLK),
            .ARESET       (ARESET),
            .sample_valid (sample_valid[g]),
            .sample_data  (sample_data[g*frame_pkg::WORD_W +: frame_pkg::WORD_W]),
            .enable       (lane_en[g]),
            .frame_len    (lane_len[g*frame_pkg::LEN_W +: frame_pkg::LEN_W]),
            .out_ready    (lane_ready[g]),
            .ovf          (lane_ovf[g]),
            .out_valid    (lane_valid[g]),
            .out_data     (lane_data[g*frame_pkg::WORD_W +: frame_pkg::WORD_W]),
            .out_last     (lane_last[g])
        );
    end

    frame_merge #(
        .NUM_LANES (NUM_LANES)
    ) u_merge (
        .ACLK       (ACLK),
        .ARESET     (ARESET),
        .lane_valid (lane_valid),
        .lane_data  (lane_data),
        .lane_last  (lane_last),
        .m_ready    (m_ready),
        .lane_ready (lane_ready),
        .m_valid    (m_valid),
        .m_data     (m_data),
        .m_last     (m_last),
        .frame_done (frame_done)
    );

endmodule

/* golden_frames.txt */
// columns packed as hex: op(1) address-or-lane(3) data(8) flag(1)
// op 1 write, 2 read (flag pslverr), 3 push, 4 expect (flag last), 5 ready mode, 6 error level
// register readback and unmapped addresses
1000000000030
2000000000030
1010000001230
2010000001230
101400000FFF0
201400000FFF0
200C000000001
2018000000001
1000000000000
// single frame on lane 0, two samples
1010000000020
1000000000010
3000123456780
30000000FFFF0
4000A50002000
4000123456780
40000000FFFF0
40005A00BBB31
// both lanes, two frames each, lane 1 goes first
1000000000000
1010000000010
1014000000010
3000CAFE00010
30000BAD00020
3001111122220
3001333344440
1000000000030
4000A51001000
4000111122220
40005A0033331
4000A50001010
4000CAFE00010
40005A01CAFF1
4000A51001010
4000333344440
40005A0177771
4000A50001020
40000BAD00020
40005A020BAF1
2008000000050
// same traffic under random back-pressure
5000000000001
1000000000000
3000CAFE00010
30000BAD00020
3001111122220
3001333344440
1000000000030
4000A51001020
4000111122220
40005A0233331
4000A50001030
4000CAFE00010
40005A03CAFF1
4000A51001030
4000333344440
40005A0377771
4000A50001040
40000BAD00020
40005A040BAF1
2008000000090
// 17 pushes into disabled lane 1
1000000000000
3001000000010
3001000000020
3001000000030
3001000000040
3001000000050
3001000000060
3001000000070
3001000000080
3001000000090
30010000000A0
30010000000B0
30010000000C0
30010000000D0
30010000000E0
30010000000F0
3001000000100
3001000000110
6000000000001
2004000000020
1004000000020
6000000000000
2004000000000
// frame count unchanged by the overflow
2008000000090

/* run_sim.sh */
#!/bin/sh
# build with Verilator, run, then judge the log
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal -f sim.f --top-module tb_frame_top \
    -o tb_frame_top > build.log 2>&1 || { cat build.log; echo "build failed"; exit 1; }
./obj_dir/tb_frame_top > sim.log 2>&1
cat sim.log
grep -q "tests failed" sim.log && { echo "simulation reported failure"; exit 1; }
grep -q "all tests passed" sim.log || { echo "simulation ended without a pass"; exit 1; }
exit 0

/* sample_fifo.sv */
`timescale 1ns/100ps

module sample_fifo #(
    parameter int FIFO_DEPTH = 16
) (
    input  logic                          ACLK,
    input  logic                          ARESET,
    input  logic                          push,
    input  frame_pkg::word_t              push_data,
    input  logic                          pop,
    output frame_pkg::word_t              pop_data,
    output logic [$clog2(FIFO_DEPTH):0]   count,
    output logic                          overflow
);

    localparam int PTR_W = $clog2(FIFO_DEPTH);

    frame_pkg::word_t   mem [FIFO_DEPTH];
    logic [PTR_W-1:0]   wr_ptr;
    logic [PTR_W-1:0]   rd_ptr;
    logic               full;
    logic               do_push;
    logic               do_pop;

    assign full    = (count == ($clog2(FIFO_DEPTH) + 1)'(FIFO_DEPTH));
    assign do_push = push && !full;
    assign do_pop  = pop && (count != '0);

    // head word is visible without a read cycle
    assign pop_data = mem[rd_ptr];

    always_ff @(posedge ACLK) begin
        if (do_push) begin
            mem[wr_ptr] <= push_data;
        end
    end

    always_ff @(posedge ACLK) begin
        if (ARESET) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            count    <= '0;
            overflow <= 1'b0;
        end else begin
            // pointers wrap on their own, depth is a power of two
            if (do_push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
            // dropped word, one-cycle flag
            overflow <= push && full;
        end
    end

    a_no_pop_when_empty: assert property (@(posedge ACLK) disable iff (ARESET)
        !(pop && count == '0));

endmodule

/* sim.f */
frame_pkg.sv
sample_fifo.sv
frame_lane.sv
frame_apb_regs.sv
frame_merge.sv
frame_top.sv
tb_frame_top.sv

/* tb_frame_top.sv */
`timescale 1ns/100ps

module tb_frame_top;

    localparam int NUM_LANES  = 2;
    localparam int FIFO_DEPTH = 16;
    localparam int GOLDEN_MAX = 256;

    logic                                   ACLK;
    logic                                   ARESET;
    logic [frame_pkg::ADDR_W-1:0]           paddr;
    logic                                   psel;
    logic                                   penable;
    logic                                   pwrite;
    frame_pkg::word_t                       pwdata;
    frame_pkg::word_t                       prdata;
    logic                                   pready;
    logic                                   pslverr;
    logic [NUM_LANES-1:0]                   sample_valid;
    logic [NUM_LANES*frame_pkg::WORD_W-1:0] sample_data;
    logic                                   m_ready;
    logic                                   m_valid;
    frame_pkg::word_t                       m_data;
    logic                                   m_last;
    logic                                   error;

    // golden line is op, address or lane, data word, flag
    logic [51:0]  golden [GOLDEN_MAX];
    // expected output words as {last, data}
    logic [32:0]  exp_q [$];
    logic [32:0]  exp_word;
    logic         random_mode;
    logic [31:0]  lfsr;
    int           line_count;
    int           cycles;
    int           cycle_limit;
    int           words_seen;

    frame_top #(
        .NUM_LANES  (NUM_LANES),
        .FIFO_DEPTH (FIFO_DEPTH)
    ) dut0 (
        .ACLK         (ACLK),
        .ARESET       (ARESET),
        .paddr        (paddr),
        .psel         (psel),
        .penable      (penable),
        .pwrite       (pwrite),
        .pwdata       (pwdata),
        .prdata       (prdata),
        .pready       (pready),
        .pslverr      (pslverr),
        .sample_valid (sample_valid),
        .sample_data  (sample_data),
        .m_ready      (m_ready),
        .m_valid      (m_valid),
        .m_data       (m_data),
        .m_last       (m_last),
        .error        (error)
    );

    always #4 ACLK = ~ACLK;

    // x^32 + x^22 + x^2 + x + 1, shifting right
    function automatic logic [31:0] lfsr_step(input logic [31:0] state);
        if (state[0]) begin
            return (state >> 1) ^ 32'h80200003;
        end else begin
            return state >> 1;
        end
    endfunction

    task stop_on_failure();
        $display("tests failed");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic check_equal(input frame_pkg::word_t got, input frame_pkg::word_t expected,
                               input string what);
        if (got !== expected) begin
            $display("FAILED at %0t ns: %s, got %h, expected %h", $time, what, got, expected);
            stop_on_failure();
        end
    endtask

    // setup cycle, then access cycle until pready
    task apb_access(input logic [frame_pkg::ADDR_W-1:0] addr, input logic write,
                    input frame_pkg::word_t wdata, output frame_pkg::word_t rdata,
                    output logic err);
        @(posedge ACLK);
        psel    <= 1'b1;
        penable <= 1'b0;
        pwrite  <= write;
        paddr   <= addr;
        pwdata  <= wdata;
        @(posedge ACLK);
        penable <= 1'b1;
        @(negedge ACLK);
        while (!pready) begin
            @(negedge ACLK);
        end
        rdata = prdata;
        err   = pslverr;
        @(posedge ACLK);
        psel    <= 1'b0;
        penable <= 1'b0;
    endtask

    task push_sample(input int lane, input frame_pkg::word_t data);
        @(posedge ACLK);
        sample_valid[lane]                                      <= 1'b1;
        sample_data[lane*frame_pkg::WORD_W +: frame_pkg::WORD_W] <= data;
        @(posedge ACLK);
        sample_valid <= '0;
    endtask

    task wait_for_drain();
        while (exp_q.size() != 0) begin
            @(posedge ACLK);
        end
    endtask

    // status reaches error a cycle after the overflow pulse
    task check_error_level(input logic expected);
        int waited;
        waited = 0;
        @(negedge ACLK);
        while (error !== expected && waited < 4) begin
            @(negedge ACLK);
            waited++;
        end
        check_equal(32'(error), 32'(expected), "error output level");
    endtask

    task run_line(input logic [51:0] line);
        logic [3:0]                    op;
        logic [frame_pkg::ADDR_W-1:0]  addr;
        frame_pkg::word_t              data;
        logic [3:0]                    flag;
        frame_pkg::word_t              rdata;
        logic                          rerr;
        op   = line[51:48];
        addr = line[47:36];
        data = line[35:4];
        flag = line[3:0];
        case (op)
            4'h1: apb_access(addr, 1'b1, data, rdata, rerr);
            4'h2: begin
                wait_for_drain();
                apb_access(addr, 1'b0, '0, rdata, rerr);
                check_equal(rdata, data, $sformatf("read data at address %h", addr));
                check_equal(32'(rerr), 32'(flag[0]), $sformatf("pslverr at address %h", addr));
            end
            4'h3: push_sample(int'(addr), data);
            4'h4: exp_q.push_back({flag[0], data});
            4'h5: begin
                @(posedge ACLK);
                random_mode <= flag[0];
            end
            4'h6: begin
                wait_for_drain();
                check_error_level(flag[0]);
            end
            default: begin
                $display("unknown opcode %h in golden line %h", op, line);
                stop_on_failure();
            end
        endcase
    endtask

    always @(posedge ACLK) begin
        if (ARESET) begin
            m_ready <= 1'b0;
        end else if (random_mode) begin
            m_ready <= lfsr[0];
            lfsr    <= lfsr_step(lfsr);
        end else begin
            m_ready <= 1'b1;
        end
    end

    // word accepted at the next rising edge
    always @(negedge ACLK) begin
        if (!ARESET && m_valid && m_ready) begin
            if (exp_q.size() == 0) begin
                $display("output word %h arrived with no expected word left", m_data);
                stop_on_failure();
            end else begin
                exp_word = exp_q.pop_front();
                check_equal(m_data, exp_word[31:0], $sformatf("output word %0d data", words_seen));
                check_equal(32'(m_last), 32'(exp_word[32]),
                            $sformatf("output word %0d last flag", words_seen));
                words_seen++;
            end
        end
    end

    always @(posedge ACLK) begin
        cycles <= cycles + 1;
        if (cycles >= cycle_limit) begin
            $display("timeout after %0d cycles, output words did not arrive", cycles);
            stop_on_failure();
        end
    end

    initial begin
        ACLK         = 1'b0;
        ARESET       = 1'b1;
        paddr        = '0;
        psel         = 1'b0;
        penable      = 1'b0;
        pwrite       = 1'b0;
        pwdata       = '0;
        sample_valid = '0;
        sample_data  = '0;
        m_ready      = 1'b0;
        random_mode  = 1'b0;
        lfsr         = 32'hd5f0;
        cycles       = 0;
        words_seen   = 0;
        for (int i = 0; i < GOLDEN_MAX; i++) begin
            golden[i] = '0;
        end
        $readmemh("golden_frames.txt", golden);
        // opcode zero ends the command list
        line_count = 0;
        while (line_count < GOLDEN_MAX && golden[line_count][51:48] != 4'h0) begin
            line_count++;
        end
        cycle_limit = 40 * line_count + 200;
        if (line_count == 0) begin
            $display("golden_frames.txt is missing or holds no command lines");
            stop_on_failure();
        end
        repeat (5) @(posedge ACLK);
        ARESET <= 1'b0;
        for (int i = 0; i < line_count; i++) begin
            run_line(golden[i]);
        end
        wait_for_drain();
        $display("all tests passed");
        $finish;
    end

endmodule
